/* all.f */
+incdir+include
src/msg_hub_pkg.sv
src/msg_fifo.sv
src/host_channel_ctrl.sv
src/msg_hub_top.sv
tb/tb_msg_hub.sv

/* include/msg_hub_defs.svh */
`ifndef MSG_HUB_DEFS_SVH
`define MSG_HUB_DEFS_SVH

// ******************************
// Assertion message text
// ******************************

// Common prefix for every assertion report raised inside the hub,
// so a log search for one tag finds the FIFO and channel failures alike
`define MSG_HUB_ASSERT_PREFIX "[msg_hub]"

`endif

/* src/host_channel_ctrl.sv */
`timescale 1ns/1ps
`include "msg_hub_defs.svh"

module host_channel_ctrl (
  input  logic                   clk,
  input  logic                   reset,
  input  msg_hub_pkg::msg_word_t host_head,
  input  logic                   host_pending,
  input  logic                   rd_empty,
  input  logic                   rd_open,
  input  logic                   app_done,
  input  logic                   wr_open,
  input  logic                   loop_empty,
  input  msg_hub_pkg::msg_push_t fpga_msg,
  output msg_hub_pkg::msg_push_t rd_push,
  output logic                   rd_eof,
  output logic                   loop_eof
);
  import msg_hub_pkg::*;

  logic marker_at_head;
  logic rd_eof_cond;
  logic loop_eof_cond;

  // ******************************
  // Application writes
  // ******************************

  // Nobody reads while the host channel is closed, so drop those words
  always_comb begin
    rd_push      = fpga_msg;
    rd_push.en   = fpga_msg.en && rd_open;
  end

  // ******************************
  // End-of-file conditions
  // ******************************

  // Marker only counts once everything ahead of it has been read out
  assign marker_at_head = host_pending && (host_head == END_MARKER);
  assign rd_eof_cond    = (marker_at_head && rd_empty) || app_done;

  // Loopback ends when the writer has closed and all copies are gone
  assign loop_eof_cond = !wr_open && loop_empty;

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_eof   <= 1'b0;
      loop_eof <= 1'b0;
    end else begin
      rd_eof   <= rd_eof_cond;
      loop_eof <= loop_eof_cond;
    end
  end

  // Channel states and the write enable must be driven once out of reset
  a_inputs_known: assert property (
    @(posedge clk) disable iff (reset)
    !$isunknown({rd_open, wr_open, app_done, fpga_msg.en})
  ) else $error("%s channel control input unknown", `MSG_HUB_ASSERT_PREFIX);

endmodule

/* src/msg_fifo.sv */
`timescale 1ns/1ps
`include "msg_hub_defs.svh"

module msg_fifo #(
  parameter int DEPTH = msg_hub_pkg::HOST_FIFO_DEPTH
) (
  input  logic                   clk,
  input  logic                   reset,
  input  msg_hub_pkg::msg_push_t push,
  input  logic                   pop,
  output msg_hub_pkg::msg_word_t head,
  output logic                   empty,
  output logic                   full
);
  import msg_hub_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  msg_word_t        mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // Wrap at DEPTH so non power of two depths also work
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Push while full is dropped, pop while empty does nothing
  assign do_push = push.en && !full;
  assign do_pop  = pop && !empty;

  assign empty = (count == '0);
  assign full  = (count == CNT_W'(DEPTH));

  // Show-ahead: the head word is valid whenever empty is low
  assign head = mem[rd_ptr];

  // ******************************
  // Storage
  // ******************************

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push.data;
    end
  end

  // ******************************
  // Pointers and occupancy
  // ******************************

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Reader must watch empty before taking a word
  a_no_pop_when_empty: assert property (
    @(posedge clk) disable iff (reset) pop |-> !empty
  ) else $error("%s pop while empty", `MSG_HUB_ASSERT_PREFIX);

  // Any word offered at the head was written with known data
  a_head_known: assert property (
    @(posedge clk) disable iff (reset) !empty |-> !$isunknown(head)
  ) else $error("%s unknown word at head", `MSG_HUB_ASSERT_PREFIX);

endmodule

/* src/msg_hub_pkg.sv */
package msg_hub_pkg;

  // ******************************
  // Message word
  // ******************************

  // Host stream word width, same on every channel
  localparam int MSG_WIDTH = 32;

  typedef logic [MSG_WIDTH-1:0] msg_word_t;

  // All ones closes the host stream
  localparam msg_word_t END_MARKER = '1;

  // ******************************
  // Queue depths
  // ******************************

  // Host-to-application and application-to-host queues
  localparam int HOST_FIFO_DEPTH = 16;

  // Loopback copies of acknowledged host words
  localparam int LOOP_FIFO_DEPTH = 8;

  // ******************************
  // Push port
  // ******************************

  // One write into a queue; en qualifies data
  typedef struct packed {
    logic      en;
    msg_word_t data;
  } msg_push_t;

endpackage

/* src/msg_hub_top.sv */
`timescale 1ns/1ps

module msg_hub_top (
  input  logic                   clk,
  input  logic                   reset,

  // Host write channel
  input  msg_hub_pkg::msg_push_t host_wr,
  output logic                   host_wr_full,
  input  logic                   host_wr_open,

  // Host read channel
  input  logic                   host_rd_en,
  output msg_hub_pkg::msg_word_t host_rd_data,
  output logic                   host_rd_empty,
  input  logic                   host_rd_open,
  output logic                   host_rd_eof,

  // Loopback channel
  input  logic                   loop_rd_en,
  output msg_hub_pkg::msg_word_t loop_rd_data,
  output logic                   loop_rd_empty,
  output logic                   loop_rd_eof,

  // Application side
  output msg_hub_pkg::msg_word_t pc_msg,
  output logic                   pc_msg_pending,
  input  logic                   pc_msg_ack,
  input  msg_hub_pkg::msg_push_t fpga_msg,
  output logic                   fpga_msg_full,
  input  logic                   app_done
);
  import msg_hub_pkg::*;

  logic      host_empty;
  msg_push_t loop_push;
  msg_push_t rd_push;

  assign pc_msg_pending = !host_empty;

  // Every acknowledged host word is copied back toward the host
  assign loop_push = '{en: pc_msg_ack, data: pc_msg};

  // ******************************
  // Queues
  // ******************************

  msg_fifo #(
    .DEPTH (HOST_FIFO_DEPTH)
  ) host_fifo (
    .clk   (clk),
    .reset (reset),
    .push  (host_wr),
    .pop   (pc_msg_ack),
    .head  (pc_msg),
    .empty (host_empty),
    .full  (host_wr_full)
  );

  msg_fifo #(
    .DEPTH (HOST_FIFO_DEPTH)
  ) rd_fifo (
    .clk   (clk),
    .reset (reset),
    .push  (rd_push),
    .pop   (host_rd_en),
    .head  (host_rd_data),
    .empty (host_rd_empty),
    .full  (fpga_msg_full)
  );

  // Full is not reported to the host, a copy arriving while full is lost
  msg_fifo #(
    .DEPTH (LOOP_FIFO_DEPTH)
  ) loop_fifo (
    .clk   (clk),
    .reset (reset),
    .push  (loop_push),
    .pop   (loop_rd_en),
    .head  (loop_rd_data),
    .empty (loop_rd_empty),
    .full  ()
  );

  // ******************************
  // Channel control
  // ******************************

  host_channel_ctrl chan_ctrl (
    .clk          (clk),
    .reset        (reset),
    .host_head    (pc_msg),
    .host_pending (pc_msg_pending),
    .rd_empty     (host_rd_empty),
    .rd_open      (host_rd_open),
    .app_done     (app_done),
    .wr_open      (host_wr_open),
    .loop_empty   (loop_rd_empty),
    .fpga_msg     (fpga_msg),
    .rd_push      (rd_push),
    .rd_eof       (host_rd_eof),
    .loop_eof     (loop_rd_eof)
  );

endmodule

/* tb/msg_hub_cases.txt */
# Columns: test name, operation, count (words or cycles), value in hex
# Value is pushed data, an input level or the expected flag, and 0 where unused
boot_rd_eof chk_rd_eof 0 0
boot_pending chk_pending 0 0
boot_rd_empty chk_rd_empty 0 1
order_push host_rand 6 0
order_pending chk_pending 0 1
order_ack ack 6 0
order_drained chk_pending 0 0
loop_read_all loop_read 6 0
loop_close wr_open 0 0
loop_eof_on wait_loop_eof 10 1
loop_reopen wr_open 0 1
loop_eof_off wait_loop_eof 10 0
burst_push host_rand 10 0
burst_ack_a ack 4 0
burst_loop_a loop_read 4 0
burst_ack_b ack 6 0
burst_loop_b loop_read 6 0
rd_push app_rand 5 0
rd_read host_read 5 0
rd_close rd_open 0 0
rd_drop app_rand 4 0
rd_idle idle 3 0
rd_stays_empty chk_rd_empty 0 1
rd_reopen rd_open 0 1
rd_again app_rand 3 0
rd_again_read host_read 3 0
marker_push host_word 1 ffffffff
marker_eof_on wait_rd_eof 10 1
marker_ack ack 1 0
marker_eof_off wait_rd_eof 10 0
marker_loop loop_read 1 0
done_set app_done 0 1
done_eof_on wait_rd_eof 10 1
done_clear app_done 0 0
done_eof_off wait_rd_eof 10 0
full_reset reset 0 0
full_rd_eof chk_rd_eof 0 0
full_fill host_force 17 0
full_flag_on chk_wr_full 0 1
full_drain ack 16 0
full_flag_off chk_wr_full 0 0
full_pending chk_pending 0 0
full_loop loop_read 8 0
full_loop_empty wait_loop_eof 10 0

/* tb/tb_msg_hub.sv */
`timescale 1ns/1ps

module tb_msg_hub;
  import msg_hub_pkg::*;

  localparam time         CLK_PERIOD   = 100ns;
  localparam time         DRIVE_DELAY  = 10ns;
  localparam int          RESET_CYCLES = 4;
  localparam int          WAIT_LIMIT   = 64;
  localparam logic [15:0] LFSR_SEED    = 16'd43420;
  localparam logic [15:0] LFSR_TAPS    = 16'hB400;
  localparam string       CASE_FILE    = "tb/msg_hub_cases.txt";

  logic      clk;
  logic      reset;
  msg_push_t host_wr;
  logic      host_wr_full;
  logic      host_wr_open;
  logic      host_rd_en;
  msg_word_t host_rd_data;
  logic      host_rd_empty;
  logic      host_rd_open;
  logic      host_rd_eof;
  logic      loop_rd_en;
  msg_word_t loop_rd_data;
  logic      loop_rd_empty;
  logic      loop_rd_eof;
  msg_word_t pc_msg;
  logic      pc_msg_pending;
  logic      pc_msg_ack;
  msg_push_t fpga_msg;
  logic      fpga_msg_full;
  logic      app_done;

  // Model queues, front is the next word the hub must show
  msg_word_t   host_q[$];
  msg_word_t   loop_q[$];
  msg_word_t   rd_q[$];
  int          errors;
  int          checks;
  logic [15:0] lfsr_state;
  int          fd;
  int          fields;
  int          count;
  logic [31:0] value;
  string       line;
  string       name;
  string       op;

  msg_hub_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ******************************
  // Helpers
  // ******************************

  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    if (state[0]) begin
      return (state >> 1) ^ LFSR_TAPS;
    end
    return state >> 1;
  endfunction

  // One LFSR step per data bit
  task automatic rand_word(output msg_word_t w);
    w = '0;
    for (int i = 0; i < MSG_WIDTH; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w = {w[MSG_WIDTH-2:0], lfsr_state[0]};
    end
  endtask

  task automatic check_value(input string test, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      $display("Fail %s expected %h actual %h", test, expected, actual);
      errors++;
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    repeat (RESET_CYCLES) next_cycle();
    reset = 1'b0;
    host_q.delete();
    loop_q.delete();
    rd_q.delete();
  endtask

  // Model keeps a word only while the host queue has room
  task automatic push_host(input string test, input msg_word_t w, input bit force_push);
    int waited;
    waited = 0;
    while (!force_push && host_wr_full && waited < WAIT_LIMIT) begin
      next_cycle();
      waited++;
    end
    if (!force_push && host_wr_full) begin
      $display("Timeout in %s: host write channel stayed full", test);
      errors++;
      return;
    end
    if (host_q.size() < HOST_FIFO_DEPTH) begin
      host_q.push_back(w);
    end
    host_wr = '{en: 1'b1, data: w};
    next_cycle();
    host_wr.en = 1'b0;
  endtask

  task automatic ack_words(input string test, input int n);
    msg_word_t expected;
    int        waited;
    for (int i = 0; i < n; i++) begin
      waited = 0;
      while (!pc_msg_pending && waited < WAIT_LIMIT) begin
        next_cycle();
        waited++;
      end
      if (!pc_msg_pending) begin
        $display("Timeout in %s: no pending host word for ack %0d", test, i);
        errors++;
        return;
      end
      if (host_q.size() == 0) begin
        $display("Error in %s: hub offers a word that was never pushed", test);
        errors++;
        return;
      end
      expected = host_q.pop_front();
      check_value(test, expected, pc_msg);
      // Loopback copy is lost when that queue is full
      if (loop_q.size() < LOOP_FIFO_DEPTH) begin
        loop_q.push_back(expected);
      end
      pc_msg_ack = 1'b1;
      next_cycle();
      pc_msg_ack = 1'b0;
    end
  endtask

  task automatic read_loop(input string test, input int n);
    int waited;
    for (int i = 0; i < n; i++) begin
      waited = 0;
      while (loop_rd_empty && waited < WAIT_LIMIT) begin
        next_cycle();
        waited++;
      end
      if (loop_rd_empty || loop_q.size() == 0) begin
        $display("Timeout in %s: loopback word %0d never arrived", test, i);
        errors++;
        return;
      end
      check_value(test, loop_q.pop_front(), loop_rd_data);
      loop_rd_en = 1'b1;
      next_cycle();
      loop_rd_en = 1'b0;
    end
    // Empty flag follows what the model still holds
    check_value(test, 32'(loop_q.size() == 0), 32'(loop_rd_empty));
  endtask

  // Words sent while the read channel is closed are not expected back
  task automatic push_app(input string test, input int n);
    msg_word_t w;
    int        waited;
    for (int i = 0; i < n; i++) begin
      rand_word(w);
      check_value(test, 32'(rd_q.size() >= HOST_FIFO_DEPTH), 32'(fpga_msg_full));
      waited = 0;
      while (fpga_msg_full && waited < WAIT_LIMIT) begin
        next_cycle();
        waited++;
      end
      if (fpga_msg_full) begin
        $display("Timeout in %s: application queue stayed full", test);
        errors++;
        return;
      end
      if (host_rd_open) begin
        rd_q.push_back(w);
      end
      fpga_msg = '{en: 1'b1, data: w};
      next_cycle();
      fpga_msg.en = 1'b0;
    end
  endtask

  task automatic read_host(input string test, input int n);
    int waited;
    for (int i = 0; i < n; i++) begin
      waited = 0;
      while (host_rd_empty && waited < WAIT_LIMIT) begin
        next_cycle();
        waited++;
      end
      if (host_rd_empty || rd_q.size() == 0) begin
        $display("Timeout in %s: host read word %0d never arrived", test, i);
        errors++;
        return;
      end
      check_value(test, rd_q.pop_front(), host_rd_data);
      host_rd_en = 1'b1;
      next_cycle();
      host_rd_en = 1'b0;
    end
  endtask

  task automatic wait_eof(input string test, input bit loopback, input int limit,
                          input logic level);
    int   waited;
    logic seen;
    waited = 0;
    seen = loopback ? loop_rd_eof : host_rd_eof;
    while (seen !== level && waited < limit) begin
      next_cycle();
      waited++;
      seen = loopback ? loop_rd_eof : host_rd_eof;
    end
    if (seen !== level) begin
      $display("Timeout in %s: end-of-file flag did not reach %0b in %0d cycles",
               test, level, limit);
      errors++;
    end
  endtask

  task automatic run_case(input string test, input string code, input int n,
                          input logic [31:0] arg);
    msg_word_t w;
    case (code)
      "reset":         apply_reset();
      "host_rand": begin
        for (int i = 0; i < n; i++) begin
          rand_word(w);
          push_host(test, w, 1'b0);
        end
      end
      "host_word": begin
        for (int i = 0; i < n; i++) begin
          push_host(test, arg, 1'b0);
        end
      end
      "host_force": begin
        for (int i = 0; i < n; i++) begin
          rand_word(w);
          push_host(test, w, 1'b1);
        end
      end
      "ack":           ack_words(test, n);
      "loop_read":     read_loop(test, n);
      "app_rand":      push_app(test, n);
      "host_read":     read_host(test, n);
      "wr_open":       host_wr_open = arg[0];
      "rd_open":       host_rd_open = arg[0];
      "app_done":      app_done = arg[0];
      "idle":          repeat (n) next_cycle();
      "chk_pending":   check_value(test, arg, 32'(pc_msg_pending));
      "chk_rd_empty":  check_value(test, arg, 32'(host_rd_empty));
      "chk_wr_full":   check_value(test, arg, 32'(host_wr_full));
      "chk_rd_eof":    check_value(test, arg, 32'(host_rd_eof));
      "wait_rd_eof":   wait_eof(test, 1'b0, n, arg[0]);
      "wait_loop_eof": wait_eof(test, 1'b1, n, arg[0]);
      default: begin
        $display("Unknown operation %s in case %s", code, test);
        errors++;
      end
    endcase
  endtask

  // ******************************
  // Main sequence
  // ******************************

  initial begin
    reset        = 1'b1;
    host_wr      = '0;
    host_wr_open = 1'b1;
    host_rd_en   = 1'b0;
    host_rd_open = 1'b1;
    loop_rd_en   = 1'b0;
    pc_msg_ack   = 1'b0;
    fpga_msg     = '0;
    app_done     = 1'b0;
    errors       = 0;
    checks       = 0;
    lfsr_state   = LFSR_SEED;
    apply_reset();

    fd = $fopen(CASE_FILE, "r");
    if (fd == 0) begin
      $display("Could not open case file %s", CASE_FILE);
      errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() < 2 || line[0] == "#") begin
          continue;
        end
        fields = $sscanf(line, "%s %s %d %h", name, op, count, value);
        if (fields != 4) begin
          $display("Malformed case line: %s", line);
          errors++;
        end else begin
          run_case(name, op, count, value);
        end
      end
      $fclose(fd);
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
